/* hdl/icache_pkg.sv */
package icache_pkg;

    // ------------------------------------------------------------
    // Cache geometry
    // ------------------------------------------------------------

    // Fetch byte address and instruction word
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;

    // One refill beat carries a full line of two words
    localparam int LINE_W    = 64;

    // Direct-mapped, 8 lines
    localparam int NUM_LINES = 8;

    // Address split: tag [31:6], index [5:3], word select [2]
    localparam int INDEX_W   = 3;
    localparam int OFFS_W    = 1;
    localparam int TAG_W     = 26;

    // Data array address is {index, word select}
    localparam int RF_ADDR_W = INDEX_W + OFFS_W;
    localparam int RF_WORDS  = 2 ** RF_ADDR_W;

    // Miss controller states
    typedef enum logic [1:0] {
        RF_IDLE   = 2'd0,
        RF_WAIT_A = 2'd1,
        RF_WAIT_B = 2'd2,
        RF_RETRY  = 2'd3
    } refill_state_e;

endpackage

/* hdl/clock_gate.sv */
`timescale 1ns/1ps

module clock_gate
(
    input  logic clk,
    input  logic en_i,
    input  logic test_en_i,
    output logic clk_o
);

    // Enable held stable while clk is high
    logic en_latched;

    // Transparent while clk low, so the enable can only change between pulses
    always_latch
    begin
        if (!clk)
        begin
            en_latched <= en_i | test_en_i;
        end
    end

    // Glitch-free gated clock
    assign clk_o = clk & en_latched;

endmodule

/* hdl/regfile_2r_2w.sv */
`timescale 1ns/1ps

module regfile_2r_2w
(
    input  logic                           clk,
    input  logic                           test_en_i,

    // Read port A
    input  logic                           ren_a_i,
    input  logic [icache_pkg::RF_ADDR_W-1:0] raddr_a_i,
    output logic [icache_pkg::DATA_W-1:0]    rdata_a_o,

    // Read port B
    input  logic                           ren_b_i,
    input  logic [icache_pkg::RF_ADDR_W-1:0] raddr_b_i,
    output logic [icache_pkg::DATA_W-1:0]    rdata_b_o,

    // Write port A
    input  logic [icache_pkg::RF_ADDR_W-1:0] waddr_a_i,
    input  logic [icache_pkg::DATA_W-1:0]    wdata_a_i,
    input  logic                           we_a_i,

    // Write port B
    input  logic [icache_pkg::RF_ADDR_W-1:0] waddr_b_i,
    input  logic [icache_pkg::DATA_W-1:0]    wdata_b_i,
    input  logic                           we_b_i
);

    import icache_pkg::*;

    // Registered read addresses
    logic [RF_ADDR_W-1:0] raddr_a_q;
    logic [RF_ADDR_W-1:0] raddr_b_q;

    // Latch storage, one word per entry
    logic [DATA_W-1:0]    mem_q [RF_WORDS];

    // Write decode and sampled write data
    logic [RF_WORDS-1:0]  wsel_a;
    logic [RF_WORDS-1:0]  wsel_b;
    logic [RF_WORDS-1:0]  wsel_b_q;
    logic [DATA_W-1:0]    wdata_a_q;
    logic [DATA_W-1:0]    wdata_b_q;

    // Gated clocks
    logic                 we_any;
    logic                 clk_we;
    logic [RF_WORDS-1:0]  word_clk;

    // ------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------

    // Address held while the port is idle
    always_ff @(posedge clk)
    begin
        if (ren_a_i)
        begin
            raddr_a_q <= raddr_a_i;
        end
        if (ren_b_i)
        begin
            raddr_b_q <= raddr_b_i;
        end
    end

    // Output mux straight over the latch array
    assign rdata_a_o = mem_q[raddr_a_q];
    assign rdata_b_o = mem_q[raddr_b_q];

    // ------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------

    assign we_any = we_a_i | we_b_i;

    // Global write gate, no toggling on the word gates when idle
    clock_gate i_cg_we
    (
        .clk       (clk),
        .en_i      (we_any),
        .test_en_i (test_en_i),
        .clk_o     (clk_we)
    );

    // One-hot write decode per port
    always_comb
    begin
        for (int i = 0; i < RF_WORDS; i++)
        begin
            wsel_a[i] = we_a_i && (waddr_a_i == RF_ADDR_W'(i));
            wsel_b[i] = we_b_i && (waddr_b_i == RF_ADDR_W'(i));
        end
    end

    // Data captured at the end of the write cycle
    always_ff @(posedge clk)
    begin
        if (we_a_i)
        begin
            wdata_a_q <= wdata_a_i;
        end
        if (we_b_i)
        begin
            wdata_b_q <= wdata_b_i;
        end
        // Port B select follows the data into the latch phase
        if (we_any)
        begin
            wsel_b_q <= wsel_b;
        end
    end

    // Per-word gate and latch, open during the high phase after the write edge
    for (genvar w = 0; w < RF_WORDS; w++)
    begin : g_word
        clock_gate i_cg_word
        (
            .clk       (clk_we),
            .en_i      (wsel_a[w] | wsel_b[w]),
            .test_en_i (test_en_i),
            .clk_o     (word_clk[w])
        );

        // Port B wins on a same-word collision
        always_latch
        begin
            if (word_clk[w])
            begin
                mem_q[w] <= wsel_b_q[w] ? wdata_b_q : wdata_a_q;
            end
        end
    end

endmodule

/* hdl/icache_tag_store.sv */
`timescale 1ns/1ps

module icache_tag_store
(
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            flush_i,

    // Lookups, one per fetch port
    input  logic [icache_pkg::ADDR_W-1:0]   lookup_addr_a_i,
    input  logic [icache_pkg::ADDR_W-1:0]   lookup_addr_b_i,
    output logic                            hit_a_o,
    output logic                            hit_b_o,

    // Tag update from the miss controller
    input  logic                            tag_we_i,
    input  logic [icache_pkg::INDEX_W-1:0]  tag_windex_i,
    input  logic [icache_pkg::TAG_W-1:0]    tag_wtag_i
);

    import icache_pkg::*;

    // Bit position of the index field
    localparam int IDX_LSB = OFFS_W + 2;

    logic [TAG_W-1:0]     tag_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    // Address fields of both lookups
    logic [INDEX_W-1:0]   idx_a;
    logic [INDEX_W-1:0]   idx_b;
    logic [TAG_W-1:0]     tag_a;
    logic [TAG_W-1:0]     tag_b;

    // ------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            valid_q <= '0;
        end
        else
        begin
            if (flush_i)
            begin
                valid_q <= '0;
            end
            // Later assignment wins, so an in-flight refill survives flush
            if (tag_we_i)
            begin
                valid_q[tag_windex_i] <= 1'b1;
            end
        end
    end

    // Tag contents only matter once the valid bit is set
    always_ff @(posedge clk)
    begin
        if (tag_we_i)
        begin
            tag_q[tag_windex_i] <= tag_wtag_i;
        end
    end

    // ------------------------------------------------------------
    // Parallel lookups
    // ------------------------------------------------------------

    assign idx_a = lookup_addr_a_i[IDX_LSB +: INDEX_W];
    assign idx_b = lookup_addr_b_i[IDX_LSB +: INDEX_W];
    assign tag_a = lookup_addr_a_i[ADDR_W-1 -: TAG_W];
    assign tag_b = lookup_addr_b_i[ADDR_W-1 -: TAG_W];

    // Hit is not qualified by request here
    assign hit_a_o = valid_q[idx_a] && (tag_q[idx_a] == tag_a);
    assign hit_b_o = valid_q[idx_b] && (tag_q[idx_b] == tag_b);

endmodule

/* hdl/icache_miss_ctrl.sv */
`timescale 1ns/1ps

module icache_miss_ctrl
(
    input  logic                              clk,
    input  logic                              rst_n_i,

    // Fetch port A
    input  logic                              fetch_req_a_i,
    input  logic [icache_pkg::ADDR_W-1:0]     fetch_addr_a_i,
    input  logic                              hit_a_i,

    // Fetch port B
    input  logic                              fetch_req_b_i,
    input  logic [icache_pkg::ADDR_W-1:0]     fetch_addr_b_i,
    input  logic                              hit_b_i,

    output logic                              fetch_valid_a_o,
    output logic                              fetch_valid_b_o,

    // Refill interface
    output logic                              refill_req_o,
    output logic [icache_pkg::ADDR_W-1:0]     refill_addr_o,
    input  logic                              refill_valid_i,
    input  logic [icache_pkg::LINE_W-1:0]     refill_data_i,

    // Tag write
    output logic                              tag_we_o,
    output logic [icache_pkg::INDEX_W-1:0]    tag_windex_o,
    output logic [icache_pkg::TAG_W-1:0]      tag_wtag_o,

    // Data array writes, even word on one port and odd word on the other
    output logic                              we_even_o,
    output logic                              we_odd_o,
    output logic [icache_pkg::RF_ADDR_W-1:0]  waddr_even_o,
    output logic [icache_pkg::RF_ADDR_W-1:0]  waddr_odd_o,
    output logic [icache_pkg::DATA_W-1:0]     wdata_even_o,
    output logic [icache_pkg::DATA_W-1:0]     wdata_odd_o
);

    import icache_pkg::*;

    localparam int IDX_LSB = OFFS_W + 2;

    refill_state_e      state_q;
    refill_state_e      state_d;

    // Line being refilled
    logic [TAG_W-1:0]   line_tag_q;
    logic [INDEX_W-1:0] line_idx_q;

    logic               miss_a;
    logic               miss_b;
    logic               load_a;
    logic               load_b;
    logic               refill_done;
    logic               block_a;
    logic               block_b;

    assign miss_a = fetch_req_a_i & ~hit_a_i;
    assign miss_b = fetch_req_b_i & ~hit_b_i;

    // ------------------------------------------------------------
    // Refill FSM
    // ------------------------------------------------------------

    always_comb
    begin
        state_d     = state_q;
        load_a      = 1'b0;
        load_b      = 1'b0;
        refill_done = 1'b0;
        case (state_q)
            // Arbitrate, port A first; RETRY repeats the lookup of both ports
            RF_IDLE, RF_RETRY:
            begin
                state_d = RF_IDLE;
                if (miss_a)
                begin
                    state_d = RF_WAIT_A;
                    load_a  = 1'b1;
                end
                else if (miss_b)
                begin
                    state_d = RF_WAIT_B;
                    load_b  = 1'b1;
                end
            end
            RF_WAIT_A, RF_WAIT_B:
            begin
                if (refill_valid_i)
                begin
                    state_d     = RF_RETRY;
                    refill_done = 1'b1;
                end
            end
            default:
            begin
                state_d = RF_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            state_q <= RF_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // Line address captured from the winning port
    always_ff @(posedge clk)
    begin
        if (load_a)
        begin
            line_tag_q <= fetch_addr_a_i[ADDR_W-1 -: TAG_W];
            line_idx_q <= fetch_addr_a_i[IDX_LSB +: INDEX_W];
        end
        else if (load_b)
        begin
            line_tag_q <= fetch_addr_b_i[ADDR_W-1 -: TAG_W];
            line_idx_q <= fetch_addr_b_i[IDX_LSB +: INDEX_W];
        end
    end

    // Request held through the wait states, drops the cycle after valid
    assign refill_req_o  = (state_q == RF_WAIT_A) || (state_q == RF_WAIT_B);
    assign refill_addr_o = {line_tag_q, line_idx_q, {IDX_LSB{1'b0}}};

    // ------------------------------------------------------------
    // Tag and array writes in the refill-valid cycle
    // ------------------------------------------------------------

    assign tag_we_o     = refill_done;
    assign tag_windex_o = line_idx_q;
    assign tag_wtag_o   = line_tag_q;

    assign we_even_o    = refill_done;
    assign we_odd_o     = refill_done;
    assign waddr_even_o = {line_idx_q, 1'b0};
    assign waddr_odd_o  = {line_idx_q, 1'b1};
    // Low word of the beat is the even word
    assign wdata_even_o = refill_data_i[DATA_W-1:0];
    assign wdata_odd_o  = refill_data_i[LINE_W-1:DATA_W];

    // ------------------------------------------------------------
    // Fetch valids
    // ------------------------------------------------------------

    // Old tag still hits during the write cycle, but its words get overwritten
    assign block_a = refill_done && (fetch_addr_a_i[IDX_LSB +: INDEX_W] == line_idx_q);
    assign block_b = refill_done && (fetch_addr_b_i[IDX_LSB +: INDEX_W] == line_idx_q);

    // A hit is accepted in its cycle, valid one cycle later
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            fetch_valid_a_o <= 1'b0;
            fetch_valid_b_o <= 1'b0;
        end
        else
        begin
            fetch_valid_a_o <= fetch_req_a_i & hit_a_i & ~block_a;
            fetch_valid_b_o <= fetch_req_b_i & hit_b_i & ~block_b;
        end
    end

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/1ps

module icache_top
(
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          test_en_i,
    input  logic                          flush_i,

    // Fetch port A
    input  logic                          fetch_req_a_i,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_a_i,
    output logic                          fetch_valid_a_o,
    output logic [icache_pkg::DATA_W-1:0] fetch_rdata_a_o,

    // Fetch port B
    input  logic                          fetch_req_b_i,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_b_i,
    output logic                          fetch_valid_b_o,
    output logic [icache_pkg::DATA_W-1:0] fetch_rdata_b_o,

    // Refill interface
    output logic                          refill_req_o,
    output logic [icache_pkg::ADDR_W-1:0] refill_addr_o,
    input  logic                          refill_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] refill_data_i
);

    import icache_pkg::*;

    // Lookup results
    logic                 hit_a;
    logic                 hit_b;

    // Tag write
    logic                 tag_we;
    logic [INDEX_W-1:0]   tag_windex;
    logic [TAG_W-1:0]     tag_wtag;

    // Array writes
    logic                 we_even;
    logic                 we_odd;
    logic [RF_ADDR_W-1:0] waddr_even;
    logic [RF_ADDR_W-1:0] waddr_odd;
    logic [DATA_W-1:0]    wdata_even;
    logic [DATA_W-1:0]    wdata_odd;

    // ------------------------------------------------------------
    // Tags and valid bits
    // ------------------------------------------------------------

    icache_tag_store i_tag_store
    (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .lookup_addr_a_i (fetch_addr_a_i),
        .lookup_addr_b_i (fetch_addr_b_i),
        .hit_a_o         (hit_a),
        .hit_b_o         (hit_b),
        .tag_we_i        (tag_we),
        .tag_windex_i    (tag_windex),
        .tag_wtag_i      (tag_wtag)
    );

    // ------------------------------------------------------------
    // Miss handling and refill
    // ------------------------------------------------------------

    icache_miss_ctrl i_miss_ctrl
    (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .fetch_req_a_i   (fetch_req_a_i),
        .fetch_addr_a_i  (fetch_addr_a_i),
        .hit_a_i         (hit_a),
        .fetch_req_b_i   (fetch_req_b_i),
        .fetch_addr_b_i  (fetch_addr_b_i),
        .hit_b_i         (hit_b),
        .fetch_valid_a_o (fetch_valid_a_o),
        .fetch_valid_b_o (fetch_valid_b_o),
        .refill_req_o    (refill_req_o),
        .refill_addr_o   (refill_addr_o),
        .refill_valid_i  (refill_valid_i),
        .refill_data_i   (refill_data_i),
        .tag_we_o        (tag_we),
        .tag_windex_o    (tag_windex),
        .tag_wtag_o      (tag_wtag),
        .we_even_o       (we_even),
        .we_odd_o        (we_odd),
        .waddr_even_o    (waddr_even),
        .waddr_odd_o     (waddr_odd),
        .wdata_even_o    (wdata_even),
        .wdata_odd_o     (wdata_odd)
    );

    // ------------------------------------------------------------
    // Data array, read address is {index, word select}
    // ------------------------------------------------------------

    regfile_2r_2w i_data_array
    (
        .clk       (clk),
        .test_en_i (test_en_i),
        .ren_a_i   (fetch_req_a_i),
        .raddr_a_i (fetch_addr_a_i[RF_ADDR_W+1:2]),
        .rdata_a_o (fetch_rdata_a_o),
        .ren_b_i   (fetch_req_b_i),
        .raddr_b_i (fetch_addr_b_i[RF_ADDR_W+1:2]),
        .rdata_b_o (fetch_rdata_b_o),
        .waddr_a_i (waddr_even),
        .wdata_a_i (wdata_even),
        .we_a_i    (we_even),
        .waddr_b_i (waddr_odd),
        .wdata_b_i (wdata_odd),
        .we_b_i    (we_odd)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk_o,
    output logic rst_n_o
);

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;

    // Free-running clock, low at time zero
    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // Reset seen low by 16 rising edges, released between edges
    initial
    begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

/* testbench/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
(
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          flush_i,

    input  logic                          req_a_i,
    input  logic [icache_pkg::ADDR_W-1:0] addr_a_i,
    input  logic                          valid_a_i,
    input  logic [icache_pkg::DATA_W-1:0] rdata_a_i,

    input  logic                          req_b_i,
    input  logic [icache_pkg::ADDR_W-1:0] addr_b_i,
    input  logic                          valid_b_i,
    input  logic [icache_pkg::DATA_W-1:0] rdata_b_i,

    input  logic                          refill_req_i,
    input  logic [icache_pkg::ADDR_W-1:0] refill_addr_i,
    input  logic                          refill_valid_i,

    output int                            errors_o,
    output int                            fetches_o,
    output int                            refills_o
);

    import icache_pkg::*;

    localparam int IDX_LSB = OFFS_W + 2;

    // Reference tag and valid state
    logic [TAG_W-1:0]     model_tag [NUM_LINES];
    logic [NUM_LINES-1:0] model_valid;

    // Expected outputs for the cycle after the last rising edge
    logic                 exp_valid_a = 1'b0;
    logic                 exp_valid_b = 1'b0;
    logic [ADDR_W-1:0]    exp_addr_a;
    logic [ADDR_W-1:0]    exp_addr_b;
    logic                 exp_refill  = 1'b0;
    logic [ADDR_W-1:0]    exp_refill_addr = '0;

    // Refill request seen at the last falling edge
    logic                 seen_refill = 1'b0;
    logic                 started     = 1'b0;
    logic                 in_reset    = 1'b1;

    logic                 miss_a;
    logic                 miss_b;
    logic                 refill_done;
    logic [INDEX_W-1:0]   done_idx;

    int                   errors  = 0;
    int                   fetches = 0;
    int                   refills = 0;

    assign errors_o  = errors;
    assign fetches_o = fetches;
    assign refills_o = refills;

    function automatic logic lookup_hits(input logic [ADDR_W-1:0] addr);
        logic [INDEX_W-1:0] idx;
        idx = addr[IDX_LSB +: INDEX_W];
        return model_valid[idx] && (model_tag[idx] == addr[ADDR_W-1 -: TAG_W]);
    endfunction

    function automatic logic [ADDR_W-1:0] line_addr(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};
    endfunction

    // Memory content rule: address XOR 5a5a_0000, rotated left by 7
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] x;
        x = addr ^ 32'h5a5a_0000;
        return {x[24:0], x[31:25]};
    endfunction

    task automatic value_error(input string test, input logic [ADDR_W-1:0] expected,
                               input logic [ADDR_W-1:0] actual);
        errors++;
        $display("[ERROR] %s: expected %08h, actual %08h at %0t", test, expected, actual,
                 $time);
    endtask

    task automatic check_port(input string name, input logic valid,
                              input logic [DATA_W-1:0] rdata, input logic exp_valid,
                              input logic [ADDR_W-1:0] addr);
        if (valid !== exp_valid)
            value_error({name, " valid"}, ADDR_W'(exp_valid), ADDR_W'(valid));
        else if (valid)
        begin
            fetches++;
            if (rdata !== expected_word(addr))
                value_error({name, " data"}, expected_word(addr), rdata);
        end
    endtask

    // ------------------------------------------------------------
    // Rising edge: sample requests, predict, update the model
    // ------------------------------------------------------------

    always @(posedge clk)
    begin
        started  = 1'b1;
        in_reset = !rst_n_i;
        if (!rst_n_i)
        begin
            model_valid = '0;
            exp_valid_a = 1'b0;
            exp_valid_b = 1'b0;
            exp_refill  = 1'b0;
        end
        else
        begin
            refill_done = seen_refill && refill_valid_i;
            done_idx    = exp_refill_addr[IDX_LSB +: INDEX_W];
            // Lookups see the tags before this edge
            miss_a = req_a_i && !lookup_hits(addr_a_i);
            miss_b = req_b_i && !lookup_hits(addr_b_i);
            // A line being replaced at this edge returns nothing
            exp_valid_a = req_a_i && !miss_a &&
                          !(refill_done && addr_a_i[IDX_LSB +: INDEX_W] == done_idx);
            exp_valid_b = req_b_i && !miss_b &&
                          !(refill_done && addr_b_i[IDX_LSB +: INDEX_W] == done_idx);
            exp_addr_a  = addr_a_i;
            exp_addr_b  = addr_b_i;
            // Refill write lands after the flush
            if (flush_i)
                model_valid = '0;
            if (refill_done)
            begin
                model_valid[done_idx] = 1'b1;
                model_tag[done_idx]   = exp_refill_addr[ADDR_W-1 -: TAG_W];
                refills++;
            end
            // Pending refill drops after valid, else port A misses first
            if (seen_refill)
                exp_refill = !refill_valid_i;
            else if (miss_a)
            begin
                exp_refill      = 1'b1;
                exp_refill_addr = line_addr(addr_a_i);
            end
            else if (miss_b)
            begin
                exp_refill      = 1'b1;
                exp_refill_addr = line_addr(addr_b_i);
            end
            else
                exp_refill = 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Falling edge: DUT outputs are settled here
    // ------------------------------------------------------------

    always @(negedge clk)
    begin
        if (started && in_reset)
        begin
            if (valid_a_i !== 1'b0)
                value_error("reset fetch_valid_a", '0, ADDR_W'(valid_a_i));
            if (valid_b_i !== 1'b0)
                value_error("reset fetch_valid_b", '0, ADDR_W'(valid_b_i));
            if (refill_req_i !== 1'b0)
                value_error("reset refill_req", '0, ADDR_W'(refill_req_i));
            seen_refill = 1'b0;
        end
        else if (started)
        begin
            check_port("port A", valid_a_i, rdata_a_i, exp_valid_a, exp_addr_a);
            check_port("port B", valid_b_i, rdata_b_i, exp_valid_b, exp_addr_b);
            if (refill_req_i !== exp_refill)
                value_error("refill_req", ADDR_W'(exp_refill), ADDR_W'(refill_req_i));
            else if (exp_refill && refill_addr_i !== exp_refill_addr)
                value_error("refill_addr", exp_refill_addr, refill_addr_i);
            seen_refill = (refill_req_i === 1'b1);
        end
    end

endmodule

/* testbench/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    import icache_pkg::*;

    // Test length and refill delay bound
    localparam int NUM_FETCH       = 300;
    localparam int MAX_DELAY       = 5;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_FETCH * (MAX_DELAY + 4) * 2;

    // Window of 16 lines is twice the cache and forces evictions
    localparam logic [ADDR_W-1:0] WIN_BASE = 32'h0004_2c00;

    logic              clk;
    logic              rst_n;
    logic              test_en;
    logic              flush;

    logic              req_a;
    logic [ADDR_W-1:0] addr_a;
    logic              valid_a;
    logic [DATA_W-1:0] rdata_a;
    logic              req_b;
    logic [ADDR_W-1:0] addr_b;
    logic              valid_b;
    logic [DATA_W-1:0] rdata_b;

    logic              refill_req;
    logic [ADDR_W-1:0] refill_addr;
    logic              refill_valid;
    logic [LINE_W-1:0] refill_data;

    int                seed;
    int                issued_a;
    int                issued_b;
    int                done_a;
    int                done_b;
    int                resp_delay;
    logic              resp_wait;

    // Counts from the checker
    int                errors;
    int                fetches;
    int                refills;

    // Backing memory content as a fixed function of the byte address
    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] x;
        x = addr ^ 32'h5a5a_0000;
        return {x[24:0], x[31:25]};
    endfunction

    // Word-aligned address inside the window
    function automatic logic [ADDR_W-1:0] random_addr();
        return WIN_BASE + ADDR_W'(($random(seed) & 32'h1f) << 2);
    endfunction

    // Retire a returned word and maybe start the next fetch
    task automatic step_port(inout logic req, inout logic [ADDR_W-1:0] addr,
                             input logic valid, inout int issued, inout int done);
        if (req && valid)
        begin
            done++;
            req = 1'b0;
        end
        // Idle about one cycle in four
        if (!req && issued < NUM_FETCH && ($random(seed) & 3) != 0)
        begin
            addr = random_addr();
            req  = 1'b1;
            issued++;
        end
    endtask

    // Memory answers with a one-cycle valid pulse after 0 to MAX_DELAY cycles
    task automatic answer_refill();
        if (refill_valid)
        begin
            refill_valid = 1'b0;
        end
        else if (refill_req)
        begin
            if (!resp_wait)
            begin
                resp_delay = ($random(seed) & 32'h7fff_ffff) % (MAX_DELAY + 1);
                resp_wait  = 1'b1;
            end
            if (resp_delay == 0)
            begin
                // Even word in the low half of the beat
                refill_data  = {mem_word(refill_addr | 32'h4), mem_word(refill_addr)};
                refill_valid = 1'b1;
                resp_wait    = 1'b0;
            end
            else
            begin
                resp_delay--;
            end
        end
    endtask

    tb_clock_gen i_clock_gen
    (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    icache_top i_dut
    (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .test_en_i       (test_en),
        .flush_i         (flush),
        .fetch_req_a_i   (req_a),
        .fetch_addr_a_i  (addr_a),
        .fetch_valid_a_o (valid_a),
        .fetch_rdata_a_o (rdata_a),
        .fetch_req_b_i   (req_b),
        .fetch_addr_b_i  (addr_b),
        .fetch_valid_b_o (valid_b),
        .fetch_rdata_b_o (rdata_b),
        .refill_req_o    (refill_req),
        .refill_addr_o   (refill_addr),
        .refill_valid_i  (refill_valid),
        .refill_data_i   (refill_data)
    );

    tb_checker i_checker
    (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .flush_i        (flush),
        .req_a_i        (req_a),
        .addr_a_i       (addr_a),
        .valid_a_i      (valid_a),
        .rdata_a_i      (rdata_a),
        .req_b_i        (req_b),
        .addr_b_i       (addr_b),
        .valid_b_i      (valid_b),
        .rdata_b_i      (rdata_b),
        .refill_req_i   (refill_req),
        .refill_addr_i  (refill_addr),
        .refill_valid_i (refill_valid),
        .errors_o       (errors),
        .fetches_o      (fetches),
        .refills_o      (refills)
    );

    // ------------------------------------------------------------
    // Stimulus changes all inputs on the falling edge
    // ------------------------------------------------------------

    initial
    begin
        seed         = 32'h6ddfa67d;
        test_en      = 1'b0;
        flush        = 1'b0;
        req_a        = 1'b0;
        addr_a       = '0;
        req_b        = 1'b0;
        addr_b       = '0;
        refill_valid = 1'b0;
        refill_data  = '0;
        issued_a     = 0;
        issued_b     = 0;
        done_a       = 0;
        done_b       = 0;
        resp_delay   = 0;
        resp_wait    = 1'b0;
        @(posedge rst_n);
        while (done_a < NUM_FETCH || done_b < NUM_FETCH)
        begin
            @(negedge clk);
            // Occasional one-cycle flush
            flush = (($random(seed) & 63) == 0);
            step_port(req_a, addr_a, valid_a, issued_a, done_a);
            step_port(req_b, addr_b, valid_b, issued_b, done_b);
            answer_refill();
        end
        flush = 1'b0;
        repeat (4)
        begin
            @(negedge clk);
            answer_refill();
        end
        $display("Checked %0d fetches, %0d refills, %0d errors", fetches, refills, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // Watchdog bound comes from the test length and the worst refill delay
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with fetches still outstanding",
                 WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* vlog.f */
hdl/icache_pkg.sv
hdl/clock_gate.sv
hdl/regfile_2r_2w.sv
hdl/icache_tag_store.sv
hdl/icache_miss_ctrl.sv
hdl/icache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_icache.sv

/* Makefile */
# Verilator build and run of the icache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Output is shown, then searched for the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
